// ==== files.f ====
source/fu_pkg.sv
source/alu_unit.sv
source/mult_stage.sv
source/mult_pipeline.sv
source/completion_arbiter.sv
source/fu_cluster.sv
tests/fu_cluster_asserts.sv
tests/fu_cluster_tb.sv

// ==== Bender.yml ====
package:
  name: fu_cluster

sources:
  - source/fu_pkg.sv
  - source/alu_unit.sv
  - source/mult_stage.sv
  - source/mult_pipeline.sv
  - source/completion_arbiter.sv
  - source/fu_cluster.sv
  - target: test
    files:
      - tests/fu_cluster_asserts.sv
      - tests/fu_cluster_tb.sv

// ==== tests/fu_cluster_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module fu_cluster_tb
  import fu_pkg::*;
();

  localparam int CLOCK_PERIOD   = 8;
  localparam int RESET_CYCLES   = 10;
  localparam int RANDOM_SEED    = 53333;
  localparam int MULT_LATENCY   = 4;
  localparam int NUM_EDGE_PAIRS = 8;
  localparam int NUM_RAND_PAIRS = 4;
  localparam int NUM_STREAM     = 30;
  localparam int NUM_ARB_ROUNDS = 4;
  localparam int NUM_BP_EACH    = 8;
  localparam int NUM_OPS = 16 * (NUM_EDGE_PAIRS + NUM_RAND_PAIRS) + NUM_STREAM
                         + 2 * NUM_ARB_ROUNDS + 2 * NUM_BP_EACH;
  localparam int WATCHDOG_CYCLES = NUM_OPS * 20 + 1000;

  typedef struct packed {
    word_t       value;
    rob_tag_t    tag;
    logic [31:0] cycle; // Acceptance cycle
  } expect_t;

  logic       clock;
  logic       reset;
  alu_req_t   alu_req;
  logic       alu_ready;
  mult_req_t  mult_req;
  logic       mult_ready;
  fu_result_t complete;
  logic       complete_ready;

  expect_t     alu_expect[$];
  expect_t     mult_expect[$];
  logic [31:0] cycle;
  logic [3:0]  alu_seq;
  logic [3:0]  mult_seq;
  logic        strict_alu;
  logic        strict_mult;

  fu_cluster u_dut (
    .clock         (clock),
    .reset         (reset),
    .alu_req       (alu_req),
    .alu_ready     (alu_ready),
    .mult_req      (mult_req),
    .mult_ready    (mult_ready),
    .complete      (complete),
    .complete_ready(complete_ready)
  );

  initial begin
    clock = 1'b0;
    forever #(CLOCK_PERIOD / 2) clock = ~clock;
  end

  function automatic word_t alu_model(input alu_func_t func, input word_t a, input word_t b);
    logic [5:0] sh;
    sh = b[5:0];
    case (func)
      ALU_ADDQ:   alu_model = a + b;
      ALU_SUBQ:   alu_model = a - b;
      ALU_AND:    alu_model = a & b;
      ALU_BIC:    alu_model = a & ~b;
      ALU_BIS:    alu_model = a | b;
      ALU_ORNOT:  alu_model = a | ~b;
      ALU_XOR:    alu_model = a ^ b;
      ALU_EQV:    alu_model = ~(a ^ b);
      ALU_SRL:    alu_model = a >> sh;
      ALU_SLL:    alu_model = a << sh;
      ALU_SRA:    alu_model = $signed(a) >>> sh;
      ALU_CMPULT: alu_model = word_t'(a < b);
      ALU_CMPEQ:  alu_model = word_t'(a == b);
      ALU_CMPULE: alu_model = word_t'(a <= b);
      ALU_CMPLT:  alu_model = word_t'($signed(a) < $signed(b));
      ALU_CMPLE:  alu_model = word_t'($signed(a) <= $signed(b));
      default:    alu_model = ALU_POISON;
    endcase
  endfunction

  function automatic word_t mult_model(input word_t a, input word_t b);
    logic [127:0] full;
    full = a * b;
    mult_model = full[63:0]; // Low half only
  endfunction

  // {opa, opb} corner cases
  function automatic logic [127:0] edge_pair(input int idx);
    case (idx)
      0:       edge_pair = {64'h0, 64'h0};
      1:       edge_pair = {64'hffff_ffff_ffff_ffff, 64'hffff_ffff_ffff_ffff};
      2:       edge_pair = {64'h8000_0000_0000_0000, 64'h7fff_ffff_ffff_ffff};
      3:       edge_pair = {64'h7fff_ffff_ffff_ffff, 64'h8000_0000_0000_0000};
      4:       edge_pair = {64'h8000_0000_0000_0000, 64'd63};
      5:       edge_pair = {64'hffff_ffff_ffff_ffff, 64'd63};
      6:       edge_pair = {64'h8000_0000_0000_0001, 64'd0};
      default: edge_pair = {64'h0123_4567_89ab_cdef, 64'hffff_ffff_ffff_ffc0};
    endcase
  endfunction

  task automatic stop_run(input string reason);
    $display("%s", reason);
    $display(">>> FAIL");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check_equal(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
    if (actual !== expected) begin
      stop_run($sformatf("Error at %0t ns: %s is %h, expected %h",
                         $time, what, actual, expected));
    end
  endtask

  task automatic check_completion(input expect_t head, input logic strict, input int latency);
    check_equal(complete.tag, head.tag, "completion tag");
    check_equal(complete.result, head.value, "completion result");
    if (strict) begin
      check_equal(cycle - head.cycle, latency, "completion latency");
    end
  endtask

  // Inputs are stable here and match what the next rising edge sees
  always @(negedge clock) begin : monitor
    expect_t entry;
    if (!reset) begin
      if (complete.valid && complete_ready) begin
        if (complete.tag[4]) begin
          if (mult_expect.size() == 0) begin
            stop_run("A multiply result completed with no multiply outstanding");
          end else begin
            entry = mult_expect.pop_front();
            check_completion(entry, strict_mult, MULT_LATENCY);
          end
        end else begin
          if (alu_expect.size() == 0) begin
            stop_run("An ALU result completed with no ALU operation outstanding");
          end else begin
            entry = alu_expect.pop_front();
            check_completion(entry, strict_alu, 1);
          end
        end
      end
      if (alu_req.valid && alu_ready) begin
        entry.value = alu_model(alu_req.func, alu_req.opa, alu_req.opb);
        entry.tag   = alu_req.tag;
        entry.cycle = cycle;
        alu_expect.push_back(entry);
      end
      if (mult_req.valid && mult_ready) begin
        entry.value = mult_model(mult_req.opa, mult_req.opb);
        entry.tag   = mult_req.tag;
        entry.cycle = cycle;
        mult_expect.push_back(entry);
      end
    end
    cycle = cycle + 1;
  end

  // ALU tags keep bit 4 clear and multiply tags set it
  task automatic issue_alu(input alu_func_t func, input word_t a, input word_t b);
    alu_req.valid = 1'b1;
    alu_req.func  = func;
    alu_req.opa   = a;
    alu_req.opb   = b;
    alu_req.tag   = {1'b0, alu_seq};
    alu_seq       = alu_seq + 1'b1;
    @(negedge clock);
    while (!alu_ready) @(negedge clock);
    @(posedge clock);
    #1;
    alu_req.valid = 1'b0;
  endtask

  task automatic issue_mult(input word_t a, input word_t b);
    mult_req.valid = 1'b1;
    mult_req.opa   = a;
    mult_req.opb   = b;
    mult_req.tag   = {1'b1, mult_seq};
    mult_seq       = mult_seq + 1'b1;
    @(negedge clock);
    while (!mult_ready) @(negedge clock);
    @(posedge clock);
    #1;
    mult_req.valid = 1'b0;
  endtask

  task automatic wait_drained();
    while (alu_expect.size() != 0 || mult_expect.size() != 0) @(negedge clock);
    @(posedge clock);
    #1;
  endtask

  task automatic reset_state();
    reset = 1'b1;
    repeat (RESET_CYCLES - 1) begin
      @(posedge clock);
      @(negedge clock);
      check_equal(complete.valid, 1'b0, "complete.valid in reset");
      check_equal(alu_ready, 1'b1, "alu_ready in reset");
      check_equal(mult_ready, 1'b1, "mult_ready in reset");
    end
    @(posedge clock);
    #1;
    reset = 1'b0;
    repeat (3) begin
      @(negedge clock);
      check_equal(complete.valid, 1'b0, "complete.valid after reset");
      check_equal(alu_ready, 1'b1, "alu_ready after reset");
      check_equal(mult_ready, 1'b1, "mult_ready after reset");
    end
    @(posedge clock);
    #1;
  endtask

  task automatic alu_ops();
    word_t a;
    word_t b;
    strict_alu     = 1'b1;
    complete_ready = 1'b1;
    for (int f = 0; f < 16; f++) begin
      for (int i = 0; i < NUM_EDGE_PAIRS + NUM_RAND_PAIRS; i++) begin
        if (i < NUM_EDGE_PAIRS) begin
          {a, b} = edge_pair(i);
        end else begin
          a = {$urandom, $urandom};
          b = {$urandom, $urandom};
        end
        issue_alu(alu_func_t'(f), a, b);
      end
    end
    wait_drained();
    strict_alu = 1'b0;
  endtask

  task automatic mult_stream();
    strict_mult    = 1'b1;
    complete_ready = 1'b1;
    repeat (NUM_STREAM) issue_mult({$urandom, $urandom}, {$urandom, $urandom});
    wait_drained();
    strict_mult = 1'b0;
  endtask

  task automatic arbitration();
    rob_tag_t mult_tag;
    rob_tag_t alu_tag;
    complete_ready = 1'b1;
    repeat (NUM_ARB_ROUNDS) begin
      mult_tag = {1'b1, mult_seq};
      issue_mult({$urandom, $urandom}, {$urandom, $urandom});
      repeat (MULT_LATENCY - 2) begin // ALU result lands with the product
        @(posedge clock);
        #1;
      end
      alu_tag = {1'b0, alu_seq};
      issue_alu(alu_func_t'($urandom % 16), {$urandom, $urandom}, {$urandom, $urandom});
      @(negedge clock);
      check_equal(complete.valid, 1'b1, "complete.valid on collision");
      check_equal(complete.tag, mult_tag, "tag of collision winner");
      check_equal(alu_ready, 1'b0, "alu_ready while ALU waits");
      @(negedge clock);
      check_equal(complete.valid, 1'b1, "complete.valid after collision");
      check_equal(complete.tag, alu_tag, "tag after collision");
      @(posedge clock);
      #1;
    end
    wait_drained();
  endtask

  task automatic back_pressure();
    logic alu_done;
    logic mult_done;
    logic alu_low;
    logic mult_low;
    alu_done       = 1'b0;
    mult_done      = 1'b0;
    alu_low        = 1'b0;
    mult_low       = 1'b0;
    complete_ready = 1'b0;
    fork
      begin
        repeat (NUM_BP_EACH) begin
          issue_alu(alu_func_t'($urandom % 16), {$urandom, $urandom}, {$urandom, $urandom});
        end
        alu_done = 1'b1;
      end
      begin
        repeat (NUM_BP_EACH) issue_mult({$urandom, $urandom}, {$urandom, $urandom});
        mult_done = 1'b1;
      end
      begin
        while (!(alu_low && mult_low)) begin
          @(negedge clock);
          if (!alu_ready) alu_low = 1'b1;
          if (!mult_ready) mult_low = 1'b1;
        end
        // Drain at random once both units stall
        while (!(alu_done && mult_done)) begin
          @(posedge clock);
          #1;
          complete_ready = $urandom % 2;
        end
      end
    join
    complete_ready = 1'b1;
    wait_drained();
  endtask

  initial begin
    void'($urandom(RANDOM_SEED));
    reset          = 1'b1;
    alu_req        = '0;
    mult_req       = '0;
    complete_ready = 1'b0;
    cycle          = '0;
    alu_seq        = '0;
    mult_seq       = '0;
    strict_alu     = 1'b0;
    strict_mult    = 1'b0;
    reset_state();
    alu_ops();
    mult_stream();
    arbitration();
    back_pressure();
    if (alu_expect.size() == 0 && mult_expect.size() == 0) begin
      $display(">>> PASS");
      $finish;
    end else begin
      $display("Results were still outstanding at the end of the tests");
      $display(">>> FAIL");
      $fatal(1, "Simulation stopped");
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clock);
    stop_run($sformatf("Timeout: the tests did not finish within %0d cycles",
                       WATCHDOG_CYCLES));
  end

endmodule

`default_nettype wire

// ==== tests/fu_cluster_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module fu_cluster_asserts
  import fu_pkg::*;
(
  input logic       clock,
  input logic       reset,
  input fu_result_t alu_result,
  input fu_result_t mult_result,
  input fu_result_t complete,
  input logic       complete_ready,
  input logic       alu_grant,
  input logic       mult_grant
);

  // A waiting multiply result owns the bus and keeps it fixed
  mult_holds_complete: assert property (
    @(posedge clock) disable iff (reset)
    complete.valid && !complete_ready && mult_result.valid |=> $stable(complete)
  ) else $error("complete changed while a multiply result was waiting");

  alu_holds_result: assert property (
    @(posedge clock) disable iff (reset)
    alu_result.valid && !alu_grant |=> $stable(alu_result)
  ) else $error("ALU result changed before it was granted");

  mult_holds_result: assert property (
    @(posedge clock) disable iff (reset)
    mult_result.valid && !mult_grant |=> $stable(mult_result)
  ) else $error("multiply result changed before it was granted");

  complete_clear_after_reset: assert property (
    @(posedge clock) reset |=> !complete.valid
  ) else $error("complete valid in the cycle after reset");

  grants_exclusive: assert property (
    @(posedge clock) disable iff (reset)
    !(alu_grant && mult_grant)
  ) else $error("both units granted in one cycle");

endmodule

bind fu_cluster fu_cluster_asserts u_asserts (
  .clock         (clock),
  .reset         (reset),
  .alu_result    (alu_result),
  .mult_result   (mult_result),
  .complete      (complete),
  .complete_ready(complete_ready),
  .alu_grant     (alu_grant),
  .mult_grant    (mult_grant)
);

`default_nettype wire

// ==== source/fu_cluster.sv ====
`timescale 1ns/1ps
`default_nettype none

module fu_cluster
  import fu_pkg::*;
#(
  parameter int NUM_MULT_STAGES = 4
) (
  input  logic       clock,
  input  logic       reset,
  input  alu_req_t   alu_req,
  output logic       alu_ready,
  input  mult_req_t  mult_req,
  output logic       mult_ready,
  output fu_result_t complete,
  input  logic       complete_ready
);

  fu_result_t alu_result;
  fu_result_t mult_result;
  logic       alu_grant;
  logic       mult_grant;

  alu_unit u_alu (
    .clock (clock),
    .reset (reset),
    .req   (alu_req),
    .ready (alu_ready),
    .grant (alu_grant),
    .result(alu_result)
  );

  mult_pipeline #(
    .NUM_MULT_STAGES(NUM_MULT_STAGES)
  ) u_mult (
    .clock (clock),
    .reset (reset),
    .req   (mult_req),
    .ready (mult_ready),
    .grant (mult_grant),
    .result(mult_result)
  );

  completion_arbiter u_arbiter (
    .alu_result    (alu_result),
    .mult_result   (mult_result),
    .complete_ready(complete_ready),
    .alu_grant     (alu_grant),
    .mult_grant    (mult_grant),
    .complete      (complete)
  );

endmodule

`default_nettype wire

// ==== source/completion_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module completion_arbiter
  import fu_pkg::*;
(
  input  fu_result_t alu_result,
  input  fu_result_t mult_result,
  input  logic       complete_ready,
  output logic       alu_grant,
  output logic       mult_grant,
  output fu_result_t complete
);

  // Multiply wins, it is the older operation
  assign mult_grant = complete_ready && mult_result.valid;
  assign alu_grant  = complete_ready && !mult_result.valid;

  always_comb begin
    if (mult_result.valid) begin
      complete = mult_result;
    end else begin
      complete = alu_result; // Invalid too when the ALU is empty
    end
  end

endmodule

`default_nettype wire

// ==== source/mult_pipeline.sv ====
`timescale 1ns/1ps
`default_nettype none

module mult_pipeline
  import fu_pkg::*;
#(
  parameter int NUM_MULT_STAGES = 4
) (
  input  logic       clock,
  input  logic       reset,
  input  mult_req_t  req,
  output logic       ready,
  input  logic       grant,
  output fu_result_t result
);

  mult_stage_t                chain [NUM_MULT_STAGES+1];
  logic [NUM_MULT_STAGES:0]   take;

  if (WORD_WIDTH % NUM_MULT_STAGES != 0) begin : g_bad_depth
    $error("NUM_MULT_STAGES must divide the word width");
  end

  // Intake record, sum starts at zero
  always_comb begin
    chain[0].valid   = req.valid;
    chain[0].product = '0;
    chain[0].mplier  = req.opb;
    chain[0].mcand   = req.opa;
    chain[0].tag     = req.tag;
  end

  assign take[NUM_MULT_STAGES] = grant; // Last stage drains on grant

  for (genvar i = 0; i < NUM_MULT_STAGES; i++) begin : g_stage
    mult_stage #(
      .NUM_MULT_STAGES(NUM_MULT_STAGES)
    ) u_stage (
      .clock      (clock),
      .reset      (reset),
      .stage_in   (chain[i]),
      .advance_out(take[i+1]),
      .take_in    (take[i]),
      .stage_out  (chain[i+1])
    );
  end

  assign ready = take[0];

  assign result.valid  = chain[NUM_MULT_STAGES].valid;
  assign result.result = chain[NUM_MULT_STAGES].product;
  assign result.tag    = chain[NUM_MULT_STAGES].tag;

endmodule

`default_nettype wire

// ==== source/mult_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module mult_stage
  import fu_pkg::*;
#(
  parameter int NUM_MULT_STAGES = 4
) (
  input  logic        clock,
  input  logic        reset,
  input  mult_stage_t stage_in,
  input  logic        advance_out,
  output logic        take_in,
  output mult_stage_t stage_out
);

  localparam int SLICE = WORD_WIDTH / NUM_MULT_STAGES;

  word_t       slice_ext;
  word_t       partial;
  mult_stage_t next_stage;

  assign slice_ext = word_t'(stage_in.mplier[SLICE-1:0]);
  assign partial   = slice_ext * stage_in.mcand; // Low 64 bits are enough

  always_comb begin
    next_stage         = stage_in;
    next_stage.product = stage_in.product + partial;
    next_stage.mplier  = stage_in.mplier >> SLICE;
    next_stage.mcand   = stage_in.mcand << SLICE;
  end

  // Can load when empty or when the current entry moves on
  assign take_in = !stage_out.valid || advance_out;

  always_ff @(posedge clock) begin
    if (reset) begin
      stage_out.valid <= 1'b0;
    end else if (take_in) begin
      stage_out <= next_stage;
    end
  end

endmodule

`default_nettype wire

// ==== source/alu_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_unit
  import fu_pkg::*;
(
  input  logic       clock,
  input  logic       reset,
  input  alu_req_t   req,
  output logic       ready,
  input  logic       grant,
  output fu_result_t result
);

  word_t  opa;
  word_t  opb;
  shamt_t shamt;
  word_t  sign_fill;
  word_t  alu_out;

  // Same sign compares like unsigned, otherwise the negative one is smaller
  function automatic logic signed_lt(input word_t a, input word_t b);
    logic lt;
    if (a[63] == b[63]) begin
      lt = (a < b);
    end else begin
      lt = a[63];
    end
    return lt;
  endfunction

  assign opa   = req.opa;
  assign opb   = req.opb;
  assign shamt = opb[5:0];

  // Upper bits for SRA, nothing left when shamt is zero
  assign sign_fill = {64{opa[63]}} << (7'd64 - {1'b0, shamt});

  always_comb begin
    case (req.func)
      ALU_ADDQ:   alu_out = opa + opb;
      ALU_SUBQ:   alu_out = opa - opb;
      ALU_AND:    alu_out = opa & opb;
      ALU_BIC:    alu_out = opa & ~opb;
      ALU_BIS:    alu_out = opa | opb;
      ALU_ORNOT:  alu_out = opa | ~opb;
      ALU_XOR:    alu_out = opa ^ opb;
      ALU_EQV:    alu_out = opa ^ ~opb;
      ALU_SRL:    alu_out = opa >> shamt;
      ALU_SLL:    alu_out = opa << shamt;
      ALU_SRA:    alu_out = (opa >> shamt) | sign_fill;
      ALU_CMPULT: alu_out = {63'd0, opa < opb};
      ALU_CMPEQ:  alu_out = {63'd0, opa == opb};
      ALU_CMPULE: alu_out = {63'd0, opa <= opb};
      ALU_CMPLT:  alu_out = {63'd0, signed_lt(opa, opb)};
      ALU_CMPLE:  alu_out = {63'd0, signed_lt(opa, opb) || (opa == opb)};
      default:    alu_out = ALU_POISON;
    endcase
  end

  // Register is free when empty or draining this cycle
  assign ready = !result.valid || grant;

  always_ff @(posedge clock) begin
    if (reset) begin
      result.valid <= 1'b0;
    end else if (ready) begin
      result.valid  <= req.valid;
      result.result <= alu_out;
      result.tag    <= req.tag;
    end
  end

endmodule

`default_nettype wire

// ==== source/fu_pkg.sv ====
`default_nettype none

package fu_pkg;

  localparam int WORD_WIDTH    = 64;
  localparam int ROB_TAG_WIDTH = 5;
  localparam int SHAMT_WIDTH   = 6;

  typedef logic [WORD_WIDTH-1:0]    word_t;
  typedef logic [ROB_TAG_WIDTH-1:0] rob_tag_t;
  typedef logic [SHAMT_WIDTH-1:0]   shamt_t;
  typedef logic [3:0]               alu_func_t;

  // ALU function codes, dense 0 to 15
  localparam alu_func_t ALU_ADDQ   = 4'd0;
  localparam alu_func_t ALU_SUBQ   = 4'd1;
  localparam alu_func_t ALU_AND    = 4'd2;
  localparam alu_func_t ALU_BIC    = 4'd3;
  localparam alu_func_t ALU_BIS    = 4'd4;
  localparam alu_func_t ALU_ORNOT  = 4'd5;
  localparam alu_func_t ALU_XOR    = 4'd6;
  localparam alu_func_t ALU_EQV    = 4'd7;
  localparam alu_func_t ALU_SRL    = 4'd8;
  localparam alu_func_t ALU_SLL    = 4'd9;
  localparam alu_func_t ALU_SRA    = 4'd10;
  localparam alu_func_t ALU_CMPULT = 4'd11;
  localparam alu_func_t ALU_CMPEQ  = 4'd12;
  localparam alu_func_t ALU_CMPULE = 4'd13;
  localparam alu_func_t ALU_CMPLT  = 4'd14;
  localparam alu_func_t ALU_CMPLE  = 4'd15;

  localparam word_t ALU_POISON = 64'hdead_c0de_bad0_f00d; // Undefined function code

  typedef struct packed {
    logic      valid;
    alu_func_t func;
    word_t     opa;
    word_t     opb;
    rob_tag_t  tag;
  } alu_req_t;

  typedef struct packed {
    logic     valid;
    word_t    opa;    // Multiplicand
    word_t    opb;    // Multiplier
    rob_tag_t tag;
  } mult_req_t;

  typedef struct packed {
    logic     valid;
    word_t    result;
    rob_tag_t tag;
  } fu_result_t;

  typedef struct packed {
    logic     valid;
    word_t    product; // Running sum
    word_t    mplier;
    word_t    mcand;
    rob_tag_t tag;
  } mult_stage_t;

endpackage

`default_nettype wire
